// File: soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// On-chip memory depth in words
`define SOC_MEM_WORDS 256

// DMA, AES and SDIO
`define SOC_NUM_IRQ 3

// Address map, one 64 KiB region per slave
`define SOC_MEM_BASE    32'h0000_0000
`define SOC_PLIC_BASE   32'h0001_0000
`define SOC_REGION_BITS 16

`endif

// File: axi_pkg.sv
`default_nettype none

`include "soc_config.svh"

package axi_pkg;

    typedef logic [`SOC_ADDR_W-1:0]     addr_t;
    typedef logic [`SOC_DATA_W-1:0]     data_t;
    typedef logic [`SOC_DATA_W/8-1:0]   strb_t;
    typedef logic [1:0]                 resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // Where the xbar sends a request
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_PLIC,
        TGT_ERR
    } target_e;

endpackage

`default_nettype wire

// File: irq_pkg.sv
`default_nettype none

`include "soc_config.svh"

package irq_pkg;

    typedef logic [`SOC_NUM_IRQ-1:0]             irq_vec_t;
    // 0 = nothing to claim, source n reads as n+1
    typedef logic [$clog2(`SOC_NUM_IRQ+1)-1:0]   irq_id_t;
    typedef logic [`SOC_REGION_BITS-1:0]         reg_ofs_t;

    localparam reg_ofs_t PLIC_PENDING_OFS = 'h0;
    localparam reg_ofs_t PLIC_ENABLE_OFS  = 'h4;
    localparam reg_ofs_t PLIC_CLAIM_OFS   = 'h8;

endpackage

`default_nettype wire

// File: axi_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if;
    import axi_pkg::*;

    logic  awvalid;
    logic  awready;
    addr_t awaddr;

    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;

    logic  bvalid;
    logic  bready;
    resp_t bresp;

    logic  arvalid;
    logic  arready;
    addr_t araddr;

    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

// File: axi_lite_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module axi_lite_xbar (
    input  logic       clk,
    input  logic       i_rst_n,
    axi_lite_if.slave  bus_m,
    axi_lite_if.master bus_mem,
    axi_lite_if.master bus_plic
);
    import axi_pkg::*;

    localparam int REGION_W = `SOC_ADDR_W - `SOC_REGION_BITS;
    localparam logic [REGION_W-1:0] MEM_REGION  =
        REGION_W'(`SOC_MEM_BASE >> `SOC_REGION_BITS);
    localparam logic [REGION_W-1:0] PLIC_REGION =
        REGION_W'(`SOC_PLIC_BASE >> `SOC_REGION_BITS);

    target_e wr_sel;
    target_e rd_sel;
    target_e wr_tgt;
    target_e rd_tgt;
    logic    wr_busy;
    logic    rd_busy;
    logic    err_wready;
    logic    err_arready;
    logic    err_bvalid;
    logic    err_rvalid;

    function automatic target_e decode(input addr_t addr);
        logic [REGION_W-1:0] region;
        region = addr[`SOC_ADDR_W-1:`SOC_REGION_BITS];
        if (region == MEM_REGION) begin
            return TGT_MEM;
        end else if (region == PLIC_REGION) begin
            return TGT_PLIC;
        end
        return TGT_ERR;
    endfunction

    assign wr_sel = decode(bus_m.awaddr);
    assign rd_sel = decode(bus_m.araddr);

    // A response still waiting at the master blocks that direction
    assign wr_busy = bus_m.bvalid;
    assign rd_busy = bus_m.rvalid;

    // Request channels
    assign bus_mem.awvalid  = bus_m.awvalid && !wr_busy && (wr_sel == TGT_MEM);
    assign bus_mem.wvalid   = bus_m.wvalid && !wr_busy && (wr_sel == TGT_MEM);
    assign bus_plic.awvalid = bus_m.awvalid && !wr_busy && (wr_sel == TGT_PLIC);
    assign bus_plic.wvalid  = bus_m.wvalid && !wr_busy && (wr_sel == TGT_PLIC);
    assign bus_mem.arvalid  = bus_m.arvalid && !rd_busy && (rd_sel == TGT_MEM);
    assign bus_plic.arvalid = bus_m.arvalid && !rd_busy && (rd_sel == TGT_PLIC);

    assign bus_mem.awaddr  = bus_m.awaddr;
    assign bus_mem.wdata   = bus_m.wdata;
    assign bus_mem.wstrb   = bus_m.wstrb;
    assign bus_mem.araddr  = bus_m.araddr;
    assign bus_plic.awaddr = bus_m.awaddr;
    assign bus_plic.wdata  = bus_m.wdata;
    assign bus_plic.wstrb  = bus_m.wstrb;
    assign bus_plic.araddr = bus_m.araddr;

    // Unmapped addresses are accepted here and answered with DECERR
    assign err_wready  = bus_m.awvalid && bus_m.wvalid && !wr_busy && (wr_sel == TGT_ERR);
    assign err_arready = bus_m.arvalid && !rd_busy && (rd_sel == TGT_ERR);

    always_comb begin
        case (wr_sel)
            TGT_MEM: begin
                bus_m.awready = bus_mem.awready;
                bus_m.wready  = bus_mem.wready;
            end
            TGT_PLIC: begin
                bus_m.awready = bus_plic.awready;
                bus_m.wready  = bus_plic.wready;
            end
            default: begin
                bus_m.awready = err_wready;
                bus_m.wready  = err_wready;
            end
        endcase
    end

    always_comb begin
        case (rd_sel)
            TGT_MEM:  bus_m.arready = bus_mem.arready;
            TGT_PLIC: bus_m.arready = bus_plic.arready;
            default:  bus_m.arready = err_arready;
        endcase
    end

    // Responses come back from the latched target
    always_comb begin
        case (wr_tgt)
            TGT_MEM: begin
                bus_m.bvalid = bus_mem.bvalid;
                bus_m.bresp  = bus_mem.bresp;
            end
            TGT_PLIC: begin
                bus_m.bvalid = bus_plic.bvalid;
                bus_m.bresp  = bus_plic.bresp;
            end
            default: begin
                bus_m.bvalid = err_bvalid;
                bus_m.bresp  = RESP_DECERR;
            end
        endcase
    end

    always_comb begin
        case (rd_tgt)
            TGT_MEM: begin
                bus_m.rvalid = bus_mem.rvalid;
                bus_m.rdata  = bus_mem.rdata;
                bus_m.rresp  = bus_mem.rresp;
            end
            TGT_PLIC: begin
                bus_m.rvalid = bus_plic.rvalid;
                bus_m.rdata  = bus_plic.rdata;
                bus_m.rresp  = bus_plic.rresp;
            end
            default: begin
                bus_m.rvalid = err_rvalid;
                bus_m.rdata  = '0;
                bus_m.rresp  = RESP_DECERR;
            end
        endcase
    end

    assign bus_mem.bready  = bus_m.bready && (wr_tgt == TGT_MEM);
    assign bus_plic.bready = bus_m.bready && (wr_tgt == TGT_PLIC);
    assign bus_mem.rready  = bus_m.rready && (rd_tgt == TGT_MEM);
    assign bus_plic.rready = bus_m.rready && (rd_tgt == TGT_PLIC);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_tgt     <= TGT_MEM;
            err_bvalid <= 1'b0;
        end else begin
            if (bus_m.awvalid && bus_m.awready) begin
                wr_tgt <= wr_sel;
            end
            if (err_wready) begin
                err_bvalid <= 1'b1;
            end else if (bus_m.bready && (wr_tgt == TGT_ERR)) begin
                err_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_tgt     <= TGT_MEM;
            err_rvalid <= 1'b0;
        end else begin
            if (bus_m.arvalid && bus_m.arready) begin
                rd_tgt <= rd_sel;
            end
            if (err_arready) begin
                err_rvalid <= 1'b1;
            end else if (bus_m.rready && (rd_tgt == TGT_ERR)) begin
                err_rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module sram_slave (
    input  logic      clk,
    input  logic      i_rst_n,
    axi_lite_if.slave bus
);
    import axi_pkg::*;

    localparam int IDX_W  = $clog2(`SOC_MEM_WORDS);
    localparam int LANES  = $bits(strb_t);

    data_t            mem [`SOC_MEM_WORDS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_fire;
    logic             rd_fire;

    // Address and data are taken together, one write outstanding
    assign bus.awready = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign bus.wready  = bus.awready;
    assign bus.arready = bus.arvalid && !bus.rvalid;
    assign bus.bresp   = RESP_OKAY;
    assign bus.rresp   = RESP_OKAY;

    assign wr_fire = bus.awvalid && bus.awready;
    assign rd_fire = bus.arvalid && bus.arready;

    // Word index, wraps at the memory depth
    assign wr_idx = bus.awaddr[IDX_W+1:2];
    assign rd_idx = bus.araddr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < LANES; b++) begin
                if (bus.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            bus.rdata <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: plic_slave.sv
`timescale 1ns/1ps
`default_nettype none

module plic_slave (
    input  logic              clk,
    input  logic              i_rst_n,
    axi_lite_if.slave         bus,
    input  irq_pkg::irq_vec_t i_irq_src,
    output logic              o_irq
);
    import axi_pkg::*;
    import irq_pkg::*;

    localparam int NUM_SRC = $bits(irq_vec_t);

    irq_vec_t src_q;
    irq_vec_t rise;
    irq_vec_t active;
    irq_vec_t claim_sel;
    irq_vec_t claim_clr;
    irq_vec_t pending;
    irq_vec_t enable;
    irq_id_t  claim_id;
    reg_ofs_t wr_ofs;
    reg_ofs_t rd_ofs;
    logic     wr_fire;
    logic     rd_fire;

    assign bus.awready = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign bus.wready  = bus.awready;
    assign bus.arready = bus.arvalid && !bus.rvalid;
    assign bus.bresp   = RESP_OKAY;
    assign bus.rresp   = RESP_OKAY;

    assign wr_fire = bus.awvalid && bus.awready;
    assign rd_fire = bus.arvalid && bus.arready;
    assign wr_ofs  = bus.awaddr[$bits(reg_ofs_t)-1:0];
    assign rd_ofs  = bus.araddr[$bits(reg_ofs_t)-1:0];

    assign rise   = i_irq_src & ~src_q;
    assign active = pending & enable;

    // Lowest set bit of the active sources
    assign claim_sel = active & (~active + 1'b1);

    always_comb begin
        claim_id = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id = irq_id_t'(i + 1);
            end
        end
    end

    assign claim_clr = (rd_fire && (rd_ofs == PLIC_CLAIM_OFS)) ? claim_sel : '0;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            src_q   <= '0;
            pending <= '0;
            enable  <= '0;
            o_irq   <= 1'b0;
        end else begin
            src_q   <= i_irq_src;
            // New edge wins over a claim in the same cycle
            pending <= (pending & ~claim_clr) | rise;
            if (wr_fire && (wr_ofs == PLIC_ENABLE_OFS) && bus.wstrb[0]) begin
                enable <= bus.wdata[NUM_SRC-1:0];
            end
            o_irq <= |active;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (rd_ofs)
                PLIC_PENDING_OFS: bus.rdata <= data_t'(pending);
                PLIC_ENABLE_OFS:  bus.rdata <= data_t'(enable);
                PLIC_CLAIM_OFS:   bus.rdata <= data_t'(claim_id);
                default:          bus.rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  logic              clk,
    input  logic              i_rst_n,

    input  logic              i_awvalid,
    output logic              o_awready,
    input  axi_pkg::addr_t    i_awaddr,

    input  logic              i_wvalid,
    output logic              o_wready,
    input  axi_pkg::data_t    i_wdata,
    input  axi_pkg::strb_t    i_wstrb,

    output logic              o_bvalid,
    input  logic              i_bready,
    output axi_pkg::resp_t    o_bresp,

    input  logic              i_arvalid,
    output logic              o_arready,
    input  axi_pkg::addr_t    i_araddr,

    output logic              o_rvalid,
    input  logic              i_rready,
    output axi_pkg::data_t    o_rdata,
    output axi_pkg::resp_t    o_rresp,

    input  irq_pkg::irq_vec_t i_irq_src,
    output logic              o_irq
);

    axi_lite_if bus_m ();
    axi_lite_if bus_mem ();
    axi_lite_if bus_plic ();

    // External master port
    assign bus_m.awvalid = i_awvalid;
    assign bus_m.awaddr  = i_awaddr;
    assign bus_m.wvalid  = i_wvalid;
    assign bus_m.wdata   = i_wdata;
    assign bus_m.wstrb   = i_wstrb;
    assign bus_m.bready  = i_bready;
    assign bus_m.arvalid = i_arvalid;
    assign bus_m.araddr  = i_araddr;
    assign bus_m.rready  = i_rready;

    assign o_awready = bus_m.awready;
    assign o_wready  = bus_m.wready;
    assign o_bvalid  = bus_m.bvalid;
    assign o_bresp   = bus_m.bresp;
    assign o_arready = bus_m.arready;
    assign o_rvalid  = bus_m.rvalid;
    assign o_rdata   = bus_m.rdata;
    assign o_rresp   = bus_m.rresp;

    axi_lite_xbar u_xbar (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .bus_m    (bus_m),
        .bus_mem  (bus_mem),
        .bus_plic (bus_plic)
    );

    // Stands in for the SDRAM slave
    sram_slave u_sram (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .bus     (bus_mem)
    );

    plic_slave u_plic (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .bus       (bus_plic),
        .i_irq_src (i_irq_src),
        .o_irq     (o_irq)
    );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 10
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// File: tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc_top;
    import axi_pkg::*;
    import irq_pkg::*;

    localparam int CLK_NS      = 10;
    localparam int RST_CYCLES  = 16;
    localparam int NUM_RAND    = 16;
    localparam int MAX_HOLD    = 9;
    // About 60 transfers of a few cycles each plus back-pressure
    localparam int NUM_XFERS   = 64;
    localparam int XFER_CYCLES = 4 + MAX_HOLD;
    localparam int TIMEOUT_NS  = 2 * (RST_CYCLES + NUM_XFERS * XFER_CYCLES) * CLK_NS;

    logic     clk;
    logic     i_rst_n;
    logic     i_awvalid;
    logic     o_awready;
    addr_t    i_awaddr;
    logic     i_wvalid;
    logic     o_wready;
    data_t    i_wdata;
    strb_t    i_wstrb;
    logic     o_bvalid;
    logic     i_bready;
    resp_t    o_bresp;
    logic     i_arvalid;
    logic     o_arready;
    addr_t    i_araddr;
    logic     o_rvalid;
    logic     i_rready;
    data_t    o_rdata;
    resp_t    o_rresp;
    irq_vec_t i_irq_src;
    logic     o_irq;

    integer   seed;
    data_t    model [`SOC_MEM_WORDS];

    tb_clkgen #(.PERIOD_NS(CLK_NS)) u_clkgen (.o_clk(clk));

    soc_top DUT (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .i_irq_src (i_irq_src),
        .o_irq     (o_irq)
    );

    task automatic protocol_error(input string what);
        $display("Protocol error: %s", what);
        $display("Verification failed");
        $fatal(1, "protocol check");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Response one cycle after the request handshake
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_awvalid && o_awready) |=> o_bvalid)
        else protocol_error("write response not valid one cycle after handshake");
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_arvalid && o_arready) |=> o_rvalid)
        else protocol_error("read response not valid one cycle after handshake");

    // Write address and write data accepted in the same cycle
    assert property (@(posedge clk) disable iff (!i_rst_n) o_awready == o_wready)
        else protocol_error("awready and wready were not raised together");

    // Held responses stay put
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp)))
        else protocol_error("write response changed while bready was low");
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp)))
        else protocol_error("read response changed while rready was low");

    // One outstanding transaction per direction
    assert property (@(posedge clk) disable iff (!i_rst_n) o_bvalid |-> !o_awready)
        else protocol_error("write accepted while a write response was pending");
    assert property (@(posedge clk) disable iff (!i_rst_n) o_rvalid |-> !o_arready)
        else protocol_error("read accepted while a read response was pending");

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic int word_idx(input addr_t addr);
        return (addr >> 2) % `SOC_MEM_WORDS;
    endfunction

    function automatic addr_t rand_mem_addr();
        return `SOC_MEM_BASE | (addr_t'($random(seed)) & 32'h0000_fffc);
    endfunction

    // Starts after a rising edge and returns on the handshake edge
    task automatic write_req(input addr_t addr, input data_t data, input strb_t strb);
        i_awvalid <= 1'b1;
        i_awaddr  <= addr;
        i_wvalid  <= 1'b1;
        i_wdata   <= data;
        i_wstrb   <= strb;
        @(negedge clk);
        while (!o_awready) @(negedge clk);
        @(posedge clk);
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
    endtask

    task automatic write_resp(output resp_t resp);
        i_bready <= 1'b1;
        @(negedge clk);
        while (!o_bvalid) @(negedge clk);
        resp = o_bresp;
        @(posedge clk);
        i_bready <= 1'b0;
    endtask

    task automatic read_req(input addr_t addr);
        i_arvalid <= 1'b1;
        i_araddr  <= addr;
        @(negedge clk);
        while (!o_arready) @(negedge clk);
        @(posedge clk);
        i_arvalid <= 1'b0;
    endtask

    task automatic read_resp(output data_t data, output resp_t resp);
        i_rready <= 1'b1;
        @(negedge clk);
        while (!o_rvalid) @(negedge clk);
        data = o_rdata;
        resp = o_rresp;
        @(posedge clk);
        i_rready <= 1'b0;
    endtask

    task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb,
                             output resp_t resp);
        write_req(addr, data, strb);
        write_resp(resp);
    endtask

    task automatic bus_read(input addr_t addr, output data_t data, output resp_t resp);
        read_req(addr);
        read_resp(data, resp);
    endtask

    task automatic pulse_source(input int src);
        i_irq_src <= irq_vec_t'(1 << src);
        @(posedge clk);
        i_irq_src <= '0;
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin
        addr_t addrs [NUM_RAND];
        addr_t a0;
        addr_t a1;
        data_t d0;
        data_t d1;
        data_t rdata;
        resp_t resp;
        int    hold;

        seed      = 32'h5151a636;
        i_rst_n   <= 1'b0;
        i_awvalid <= 1'b0;
        i_awaddr  <= '0;
        i_wvalid  <= 1'b0;
        i_wdata   <= '0;
        i_wstrb   <= '0;
        i_bready  <= 1'b0;
        i_arvalid <= 1'b0;
        i_araddr  <= '0;
        i_rready  <= 1'b0;
        i_irq_src <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;

        @(negedge clk);
        check_value("reset_ready", 0, {o_awready, o_wready, o_arready});
        check_value("reset_valid", 0, {o_bvalid, o_rvalid});
        check_value("reset_irq", 0, o_irq);
        @(posedge clk);

        // Random full-word writes and read back through the model
        for (int i = 0; i < NUM_RAND; i++) begin
            addrs[i] = rand_mem_addr();
            d0 = $random(seed);
            model[word_idx(addrs[i])] = d0;
            bus_write(addrs[i], d0, 4'hf, resp);
            check_value("mem_write_resp", RESP_OKAY, resp);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            bus_read(addrs[i], rdata, resp);
            check_value("mem_read_resp", RESP_OKAY, resp);
            check_value("mem_read_data", model[word_idx(addrs[i])], rdata);
        end

        // Partial strobes
        d0 = $random(seed);
        model[word_idx(addrs[2])] = merge_bytes(model[word_idx(addrs[2])], d0, 4'b0101);
        bus_write(addrs[2], d0, 4'b0101, resp);
        d1 = $random(seed);
        model[word_idx(addrs[2])] = merge_bytes(model[word_idx(addrs[2])], d1, 4'b1000);
        bus_write(addrs[2], d1, 4'b1000, resp);
        bus_read(addrs[2], rdata, resp);
        check_value("strobe_merge", model[word_idx(addrs[2])], rdata);

        // Unmapped region
        bus_write(32'h0002_0010, 32'hdead_beef, 4'hf, resp);
        check_value("decerr_write_resp", RESP_DECERR, resp);
        bus_read(32'h0003_0020, rdata, resp);
        check_value("decerr_read_resp", RESP_DECERR, resp);
        check_value("decerr_read_data", 0, rdata);

        // Pending bits and masking by enable
        for (int s = 0; s < `SOC_NUM_IRQ; s++) begin
            pulse_source(s);
            bus_read(`SOC_PLIC_BASE + PLIC_PENDING_OFS, rdata, resp);
            check_value("irq_pending", (1 << (s + 1)) - 1, rdata);
            @(negedge clk);
            check_value("irq_masked", 0, o_irq);
            @(posedge clk);
            bus_write(`SOC_PLIC_BASE + PLIC_ENABLE_OFS, 1 << s, 4'hf, resp);
            @(negedge clk);
            check_value("irq_enabled", 1, o_irq);
            @(posedge clk);
            bus_write(`SOC_PLIC_BASE + PLIC_ENABLE_OFS, 0, 4'hf, resp);
        end

        // Claims come out lowest source first
        bus_write(`SOC_PLIC_BASE + PLIC_ENABLE_OFS, 32'h7, 4'hf, resp);
        for (int s = 0; s < `SOC_NUM_IRQ; s++) begin
            bus_read(`SOC_PLIC_BASE + PLIC_CLAIM_OFS, rdata, resp);
            check_value("claim_id", s + 1, rdata);
        end
        @(negedge clk);
        check_value("irq_after_claims", 0, o_irq);
        @(posedge clk);
        bus_read(`SOC_PLIC_BASE + PLIC_CLAIM_OFS, rdata, resp);
        check_value("claim_empty", 0, rdata);

        // Write back-pressure with a second write waiting
        a0 = rand_mem_addr();
        a1 = a0 ^ 32'h0000_0004;
        d0 = $random(seed);
        d1 = $random(seed);
        hold = 1 + ({$random(seed)} % MAX_HOLD);
        write_req(a0, d0, 4'hf);
        model[word_idx(a0)] = d0;
        i_awvalid <= 1'b1;
        i_awaddr  <= a1;
        i_wvalid  <= 1'b1;
        i_wdata   <= d1;
        repeat (hold) begin
            @(negedge clk);
            check_value("bp_write_blocked", 0, o_awready);
            @(posedge clk);
        end
        write_resp(resp);
        check_value("bp_write_resp", RESP_OKAY, resp);
        write_req(a1, d1, 4'hf);
        model[word_idx(a1)] = d1;
        write_resp(resp);

        // Read back-pressure with a second read waiting
        hold = 1 + ({$random(seed)} % MAX_HOLD);
        read_req(a0);
        i_arvalid <= 1'b1;
        i_araddr  <= a1;
        repeat (hold) begin
            @(negedge clk);
            check_value("bp_read_blocked", 0, o_arready);
            @(posedge clk);
        end
        read_resp(rdata, resp);
        check_value("bp_read_first", model[word_idx(a0)], rdata);
        read_req(a1);
        read_resp(rdata, resp);
        check_value("bp_read_second", model[word_idx(a1)], rdata);

        repeat (2) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
axi_pkg.sv
irq_pkg.sv
axi_lite_if.sv
axi_lite_xbar.sv
sram_slave.sv
plic_slave.sv
soc_top.sv
tb_clkgen.sv
tb_soc_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_soc_top -o sim_tb_soc_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb_soc_top > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
